// ==== verilog/arch_defs_pkg.sv ====
package arch_defs_pkg;

    // Width of one UART data word.
    localparam int DATA_WIDTH = 8;

    // One transmitter FSM state per part of the frame.
    typedef enum logic [1:0] {
        S_UART_TX_IDLE      = 2'b00,   // Line high, waiting for a start pulse.
        S_UART_TX_START     = 2'b01,   // Start bit, line low.
        S_UART_TX_SEND_DATA = 2'b10,   // Data bits, LSB first.
        S_UART_TX_STOP      = 2'b11    // Stop bit, line high.
    } uart_fsm_state_t;

endpackage

// ==== verilog/uart_regs_pkg.sv ====
package uart_regs_pkg;

    // APB bus widths.
    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    // Register map.
    // Channel n data register sits at ADDR_TX_DATA_BASE + 4*n.
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_TX_DATA_BASE = 8'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_STATUS       = 8'h20;   // Read-only busy bits.
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_DONE         = 8'h24;   // Sticky W1C flags.
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_IRQ_EN       = 8'h28;   // Interrupt enables.

endpackage

// ==== verilog/uart_transmitter.sv ====
`timescale 1ns/1ns

module uart_transmitter #(
    parameter int CLOCK_SPEED = 50_000_000,
    parameter int BAUD_RATE   = 115_200
) (
    input  logic                                clk,
    input  logic                                reset,

    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] i_tx_data,
    input  logic                                i_tx_start,

    output logic                                o_tx_busy,
    output logic                                o_tx_serial
);

    localparam int DW             = arch_defs_pkg::DATA_WIDTH;
    localparam int CYCLES_PER_BIT = CLOCK_SPEED / BAUD_RATE;
    localparam int BIT_CNT_W      = $clog2(DW);
    localparam int BAUD_CNT_W     = $clog2(CYCLES_PER_BIT + 1);   // Count reaches CYCLES_PER_BIT.

    localparam logic LINE_IDLE  = 1'b1;
    localparam logic LINE_START = 1'b0;
    localparam logic LINE_STOP  = 1'b1;

    arch_defs_pkg::uart_fsm_state_t current_state, next_state;

    logic [DW-1:0]         shift_reg;
    logic [BIT_CNT_W-1:0]  bit_count, next_bit_count;
    logic [BAUD_CNT_W-1:0] baud_count, next_baud_count;
    logic                  busy_next;
    logic                  event_end_of_bit;

    logic cmd_enable_baud_count;
    logic cmd_reset_baud_count;
    logic cmd_latch_data;
    logic cmd_shift_data;

    always_comb begin
        next_state     = current_state;
        next_bit_count = bit_count;
        o_tx_serial    = LINE_IDLE;
        busy_next      = 1'b0;

        cmd_enable_baud_count = 1'b0;
        cmd_reset_baud_count  = 1'b0;
        cmd_latch_data        = 1'b0;
        cmd_shift_data        = 1'b0;

        case (current_state)
            arch_defs_pkg::S_UART_TX_IDLE: begin
                if (i_tx_start) begin
                    busy_next            = 1'b1;
                    cmd_latch_data       = 1'b1;
                    cmd_reset_baud_count = 1'b1;
                    next_bit_count       = '0;
                    next_state           = arch_defs_pkg::S_UART_TX_START;
                end
            end

            arch_defs_pkg::S_UART_TX_START: begin
                o_tx_serial           = LINE_START;
                busy_next             = 1'b1;
                cmd_enable_baud_count = 1'b1;
                if (event_end_of_bit) begin
                    cmd_reset_baud_count = 1'b1;
                    next_state           = arch_defs_pkg::S_UART_TX_SEND_DATA;
                end
            end

            arch_defs_pkg::S_UART_TX_SEND_DATA: begin
                o_tx_serial           = shift_reg[0];   // LSB goes out first.
                busy_next             = 1'b1;
                cmd_enable_baud_count = 1'b1;
                if (event_end_of_bit) begin
                    cmd_shift_data       = 1'b1;
                    cmd_reset_baud_count = 1'b1;
                    if (bit_count == BIT_CNT_W'(DW - 1)) begin
                        next_bit_count = '0;
                        next_state     = arch_defs_pkg::S_UART_TX_STOP;
                    end else begin
                        next_bit_count = bit_count + 1'b1;
                    end
                end
            end

            arch_defs_pkg::S_UART_TX_STOP: begin
                o_tx_serial           = LINE_STOP;
                busy_next             = 1'b1;
                cmd_enable_baud_count = 1'b1;
                if (event_end_of_bit) begin
                    busy_next            = 1'b0;   // Busy drops as the stop bit ends.
                    cmd_reset_baud_count = 1'b1;
                    next_state           = arch_defs_pkg::S_UART_TX_IDLE;
                end
            end

            default: begin
                next_state = arch_defs_pkg::S_UART_TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_state <= arch_defs_pkg::S_UART_TX_IDLE;
            bit_count     <= '0;
            o_tx_busy     <= 1'b0;
        end else begin
            current_state <= next_state;
            bit_count     <= next_bit_count;
            o_tx_busy     <= busy_next;
        end
    end

    // Shift register refills with ones from the top.
    always_ff @(posedge clk) begin
        if (cmd_latch_data) begin
            shift_reg <= i_tx_data;
        end else if (cmd_shift_data) begin
            shift_reg <= {1'b1, shift_reg[DW-1:1]};
        end
    end

    // Baud counter
    always_comb begin
        next_baud_count = baud_count;
        if (cmd_reset_baud_count) begin
            next_baud_count = '0;
        end else if (cmd_enable_baud_count) begin
            next_baud_count = baud_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            baud_count       <= '0;
            event_end_of_bit <= 1'b0;
        end else begin
            baud_count       <= next_baud_count;
            // Registered, so each bit lasts CYCLES_PER_BIT+1 clocks.
            event_end_of_bit <= cmd_enable_baud_count &&
                                (baud_count == BAUD_CNT_W'(CYCLES_PER_BIT - 1));
        end
    end

endmodule

// ==== verilog/uart_apb_regs.sv ====
`timescale 1ns/1ns

module uart_apb_regs #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,

    input  logic                                      i_psel,
    input  logic                                      i_penable,
    input  logic                                      i_pwrite,
    input  logic [uart_regs_pkg::APB_ADDR_WIDTH-1:0]  i_paddr,
    input  logic [uart_regs_pkg::APB_DATA_WIDTH-1:0]  i_pwdata,
    output logic [uart_regs_pkg::APB_DATA_WIDTH-1:0]  o_prdata,

    input  logic [NUM_CHANNELS-1:0]                   i_tx_busy,
    input  logic [NUM_CHANNELS-1:0]                   i_done,

    output logic [NUM_CHANNELS-1:0][arch_defs_pkg::DATA_WIDTH-1:0] o_tx_data,
    output logic [NUM_CHANNELS-1:0]                   o_tx_start,
    output logic [NUM_CHANNELS-1:0]                   o_done_clear,
    output logic [NUM_CHANNELS-1:0]                   o_irq_en
);

    localparam int DW = arch_defs_pkg::DATA_WIDTH;
    localparam int AW = uart_regs_pkg::APB_ADDR_WIDTH;
    localparam int PW = uart_regs_pkg::APB_DATA_WIDTH;

    typedef logic [AW-1:0] addr_t;

    logic                    wr_access;   // Access phase of a write.
    logic                    rd_setup;    // Setup phase of a read.
    logic [NUM_CHANNELS-1:0] data_hit;
    logic                    status_hit;
    logic                    done_hit;
    logic                    irq_en_hit;
    logic [PW-1:0]           rd_mux;

    assign wr_access = i_psel & i_penable & i_pwrite;
    assign rd_setup  = i_psel & ~i_penable & ~i_pwrite;

    // Address decode.
    always_comb begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            data_hit[ch] = (i_paddr == uart_regs_pkg::ADDR_TX_DATA_BASE + addr_t'(4 * ch));
        end
    end

    assign status_hit = (i_paddr == uart_regs_pkg::ADDR_STATUS);
    assign done_hit   = (i_paddr == uart_regs_pkg::ADDR_DONE);
    assign irq_en_hit = (i_paddr == uart_regs_pkg::ADDR_IRQ_EN);

    // Data words.
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (wr_access && data_hit[ch]) begin
                o_tx_data[ch] <= i_pwdata[DW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_tx_start   <= '0;
            o_done_clear <= '0;
            o_irq_en     <= '0;
        end else begin
            o_tx_start   <= data_hit & {NUM_CHANNELS{wr_access}};   // One cycle pulse.
            o_done_clear <= (wr_access && done_hit) ? i_pwdata[NUM_CHANNELS-1:0] : '0;
            if (wr_access && irq_en_hit) begin
                o_irq_en <= i_pwdata[NUM_CHANNELS-1:0];
            end
        end
    end

    // Read mux. Unmapped addresses fall through as zero.
    always_comb begin
        rd_mux = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (data_hit[ch]) begin
                rd_mux[DW-1:0] = o_tx_data[ch];
            end
        end
        if (status_hit) begin
            rd_mux[NUM_CHANNELS-1:0] = i_tx_busy;
        end
        if (done_hit) begin
            rd_mux[NUM_CHANNELS-1:0] = i_done;
        end
        if (irq_en_hit) begin
            rd_mux[NUM_CHANNELS-1:0] = o_irq_en;
        end
    end

    // Captured at the end of setup and held through the access cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            o_prdata <= '0;
        end else if (rd_setup) begin
            o_prdata <= rd_mux;
        end
    end

endmodule

// ==== verilog/uart_tx_done_collector.sv ====
`timescale 1ns/1ns

module uart_tx_done_collector #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic [NUM_CHANNELS-1:0] i_tx_busy,
    input  logic [NUM_CHANNELS-1:0] i_done_clear,
    input  logic [NUM_CHANNELS-1:0] i_irq_en,

    output logic [NUM_CHANNELS-1:0] o_done,
    output logic                    o_irq
);

    logic [NUM_CHANNELS-1:0] busy_q;
    logic [NUM_CHANNELS-1:0] busy_fell;

    assign busy_fell = busy_q & ~i_tx_busy;   // End of a frame.

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= '0;
            o_done <= '0;
        end else begin
            busy_q <= i_tx_busy;
            // A new frame end beats a clear in the same cycle.
            o_done <= (o_done & ~i_done_clear) | busy_fell;
        end
    end

    assign o_irq = |(o_done & i_irq_en);

endmodule

// ==== verilog/uart_tx_array.sv ====
`timescale 1ns/1ns

module uart_tx_array #(
    parameter int NUM_CHANNELS = 4,            // At most 8.
    parameter int CLOCK_SPEED  = 50_000_000,
    parameter int BAUD_RATE    = 115_200
) (
    input  logic                                      clk,
    input  logic                                      reset,

    input  logic                                      i_psel,
    input  logic                                      i_penable,
    input  logic                                      i_pwrite,
    input  logic [uart_regs_pkg::APB_ADDR_WIDTH-1:0]  i_paddr,
    input  logic [uart_regs_pkg::APB_DATA_WIDTH-1:0]  i_pwdata,
    output logic [uart_regs_pkg::APB_DATA_WIDTH-1:0]  o_prdata,

    output logic [NUM_CHANNELS-1:0]                   o_txd,
    output logic                                      o_irq
);

    logic [NUM_CHANNELS-1:0][arch_defs_pkg::DATA_WIDTH-1:0] tx_data;
    logic [NUM_CHANNELS-1:0] tx_start;
    logic [NUM_CHANNELS-1:0] tx_busy;
    logic [NUM_CHANNELS-1:0] done;
    logic [NUM_CHANNELS-1:0] done_clear;
    logic [NUM_CHANNELS-1:0] irq_en;

    uart_apb_regs #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) i_uart_apb_regs (
        .clk          (clk),
        .reset        (reset),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .i_tx_busy    (tx_busy),
        .i_done       (done),
        .o_tx_data    (tx_data),
        .o_tx_start   (tx_start),
        .o_done_clear (done_clear),
        .o_irq_en     (irq_en)
    );

    // One transmitter per channel.
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
        uart_transmitter #(
            .CLOCK_SPEED (CLOCK_SPEED),
            .BAUD_RATE   (BAUD_RATE)
        ) i_uart_transmitter (
            .clk         (clk),
            .reset       (reset),
            .i_tx_data   (tx_data[ch]),
            .i_tx_start  (tx_start[ch]),
            .o_tx_busy   (tx_busy[ch]),
            .o_tx_serial (o_txd[ch])
        );
    end

    uart_tx_done_collector #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) i_uart_tx_done_collector (
        .clk          (clk),
        .reset        (reset),
        .i_tx_busy    (tx_busy),
        .i_done_clear (done_clear),
        .i_irq_en     (irq_en),
        .o_done       (done),
        .o_irq        (o_irq)
    );

endmodule

// ==== bench/tb_uart_tx_array.sv ====
`timescale 1ns/1ns

module tb_uart_tx_array;

    localparam int NUM_CHANNELS = 4;
    localparam int CLOCK_SPEED  = 25_000_000;
    localparam int BAUD_RATE    = 3_125_000;
    localparam int DW           = arch_defs_pkg::DATA_WIDTH;
    localparam int BIT_CLKS     = CLOCK_SPEED / BAUD_RATE + 1;   // 9 clocks per bit.
    localparam int FRAME_CLKS   = (DW + 2) * BIT_CLKS;
    localparam int NUM_TESTS    = 5;
    localparam int CLK_PERIOD   = 40;

    localparam logic [7:0] DATA_BASE = uart_regs_pkg::ADDR_TX_DATA_BASE;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [7:0]              paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic [NUM_CHANNELS-1:0] txd;
    logic                    irq;
    logic [15:0]             lfsr_state = 16'd58388;

    uart_tx_array #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .CLOCK_SPEED  (CLOCK_SPEED),
        .BAUD_RATE    (BAUD_RATE)
    ) i_uart_tx_array (
        .clk       (clk),
        .reset     (reset),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_txd     (txd),
        .o_irq     (irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on failure.");
    endtask

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            abort_run();
        end
    endtask

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output logic [DW-1:0] w);
        for (int i = 0; i < DW; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i]       = lfsr_state[0];
        end
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_drive_slot();
        penable = 1'b1;
        next_drive_slot();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        next_drive_slot();
        penable = 1'b1;
        data    = prdata;   // Registered at the end of setup.
        next_drive_slot();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Samples each bit about halfway through.
    task automatic decode_frame(input int ch, output logic [DW-1:0] data);
        logic line_low;
        line_low = 1'b0;
        while (!line_low) begin
            @(posedge clk);
            #1;
            line_low = (txd[ch] == 1'b0);
        end
        repeat (BIT_CLKS / 2) @(posedge clk);
        #10;
        if (txd[ch] !== 1'b0) begin
            stop_on_failure($sformatf("Channel %0d start bit did not stay low.", ch));
        end
        for (int i = 0; i < DW; i++) begin
            repeat (BIT_CLKS) @(posedge clk);
            #10;
            data[i] = txd[ch];
        end
        repeat (BIT_CLKS) @(posedge clk);
        #10;
        if (txd[ch] !== 1'b1) begin
            stop_on_failure($sformatf("Channel %0d stop bit was not high.", ch));
        end
    endtask

    task automatic wait_channel_idle(input int ch);
        logic [31:0] rd;
        int          tries;
        rd    = '1;
        tries = 0;
        while (rd[ch] && tries < FRAME_CLKS) begin
            apb_read(uart_regs_pkg::ADDR_STATUS, rd);
            tries++;
        end
        if (rd[ch]) begin
            stop_on_failure($sformatf("Channel %0d stayed busy after its frame.", ch));
        end
    endtask

    task automatic verify_reset_state();
        logic [31:0] rd;
        check_value("o_txd", txd, 32'hF);
        check_value("o_irq", irq, 32'h0);
        apb_read(uart_regs_pkg::ADDR_STATUS, rd);
        check_value("STATUS", rd, 32'h0);
        apb_read(uart_regs_pkg::ADDR_DONE, rd);
        check_value("DONE", rd, 32'h0);
        apb_read(uart_regs_pkg::ADDR_IRQ_EN, rd);
        check_value("IRQ_EN", rd, 32'h0);
    endtask

    task automatic single_frame();
        logic [DW-1:0] word;
        logic [DW-1:0] got;
        logic [31:0]   rd;
        random_word(word);
        fork
            decode_frame(0, got);
            begin
                apb_write(DATA_BASE, word);
                repeat (2 * BIT_CLKS) @(posedge clk);   // Well inside the frame.
                #2;
                apb_read(uart_regs_pkg::ADDR_STATUS, rd);
                check_value("STATUS[0] in frame", rd[0], 32'h1);
            end
        join
        check_value("txd[0] word", got, word);
        next_drive_slot();
        wait_channel_idle(0);
    endtask

    task automatic concurrent_channels();
        logic [DW-1:0] words [NUM_CHANNELS];
        logic [DW-1:0] got [NUM_CHANNELS];
        logic          dup;
        logic [31:0]   rd;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            do begin
                random_word(words[ch]);
                dup = 1'b0;
                for (int k = 0; k < ch; k++) begin
                    dup |= (words[k] == words[ch]);
                end
            end while (dup);
        end
        fork
            decode_frame(0, got[0]);
            decode_frame(1, got[1]);
            decode_frame(2, got[2]);
            decode_frame(3, got[3]);
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                apb_write(DATA_BASE + 8'(4 * ch), words[ch]);
            end
        join
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            check_value($sformatf("txd[%0d] word", ch), got[ch], words[ch]);
        end
        next_drive_slot();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            wait_channel_idle(ch);
        end
        // Each data register reads back the last word written to it.
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            apb_read(DATA_BASE + 8'(4 * ch), rd);
            check_value($sformatf("TX_DATA[%0d]", ch), rd, words[ch]);
        end
    endtask

    task automatic dropped_start();
        logic [DW-1:0] first;
        logic [DW-1:0] second;
        logic [DW-1:0] got;
        random_word(first);
        random_word(second);
        if (second == first) begin
            second = ~first;
        end
        fork
            decode_frame(1, got);
            begin
                apb_write(DATA_BASE + 8'd4, first);
                repeat (3 * BIT_CLKS) @(posedge clk);
                #2;
                apb_write(DATA_BASE + 8'd4, second);   // Channel still busy.
            end
        join
        check_value("txd[1] word", got, first);
        for (int i = 0; i < 2 * FRAME_CLKS; i++) begin
            @(posedge clk);
            #1;
            if (txd[1] !== 1'b1) begin
                stop_on_failure("Channel 1 started a frame from a start sent while busy.");
            end
        end
        next_drive_slot();
    endtask

    task automatic done_flags_and_irq();
        logic [DW-1:0] word;
        logic [DW-1:0] got;
        logic [31:0]   rd;
        apb_write(uart_regs_pkg::ADDR_DONE, 32'hF);   // Flags left from earlier frames.
        next_drive_slot();
        apb_read(uart_regs_pkg::ADDR_DONE, rd);
        check_value("DONE after clear", rd, 32'h0);
        random_word(word);
        fork
            decode_frame(2, got);
            apb_write(DATA_BASE + 8'd8, word);
        join
        check_value("txd[2] word", got, word);
        next_drive_slot();
        wait_channel_idle(2);
        apb_read(uart_regs_pkg::ADDR_DONE, rd);
        check_value("DONE after frame", rd, 32'h4);
        check_value("o_irq disabled", irq, 32'h0);
        apb_write(uart_regs_pkg::ADDR_IRQ_EN, 32'h4);
        check_value("o_irq enabled", irq, 32'h1);
        apb_write(uart_regs_pkg::ADDR_DONE, 32'h0);
        apb_read(uart_regs_pkg::ADDR_DONE, rd);
        check_value("DONE after zero write", rd, 32'h4);
        check_value("o_irq after zero write", irq, 32'h1);
        apb_write(uart_regs_pkg::ADDR_DONE, 32'h4);
        next_drive_slot();   // Clear lands one clock after the write.
        check_value("o_irq after clear", irq, 32'h0);
        apb_read(uart_regs_pkg::ADDR_DONE, rd);
        check_value("DONE after W1C", rd, 32'h0);
    endtask

    initial begin : watchdog
        #(NUM_TESTS * 4 * FRAME_CLKS * 2 * CLK_PERIOD);
        stop_on_failure("Timeout: the tests did not finish in time.");
    end

    initial begin
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        next_drive_slot();

        verify_reset_state();
        single_frame();
        concurrent_channels();
        dropped_start();
        done_flags_and_irq();

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== src.f ====
verilog/arch_defs_pkg.sv
verilog/uart_regs_pkg.sv
verilog/uart_transmitter.sv
verilog/uart_apb_regs.sv
verilog/uart_tx_done_collector.sv
verilog/uart_tx_array.sv
bench/tb_uart_tx_array.sv

// ==== Bender.yml ====
package:
  name: uart_tx_array

sources:
  - verilog/arch_defs_pkg.sv
  - verilog/uart_regs_pkg.sv
  - verilog/uart_transmitter.sv
  - verilog/uart_apb_regs.sv
  - verilog/uart_tx_done_collector.sv
  - verilog/uart_tx_array.sv
  - target: test
    files:
      - bench/tb_uart_tx_array.sv
